//--- src.f
+incdir+.
rv_decode_pkg.sv
instr_fetch.sv
instr_queue.sv
instruction_decoder.sv
rv_decode_top.sv
rv_decode_chk.sv
rv_decode_tb.sv

//--- run.sh
#!/bin/sh
# Compile with assertions on, then run; exit status carries pass or fail
verilator --binary --timing --assert -Wno-fatal --top-module rv_decode_tb \
    -f src.f -o rv_decode_sim \
    && ./obj_dir/rv_decode_sim \
    || { echo "simulation did not pass"; exit 1; }

//--- rv_decode_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module rv_decode_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 3;
    localparam int IMEM_WORDS    = `RV_IMEM_WORDS;
    localparam int AW            = $clog2(IMEM_WORDS);
    localparam int PASSES        = 3;
    localparam int TOTAL_RESULTS = PASSES * IMEM_WORDS;
    // Two cycles per instruction, doubled for ready low half the time
    localparam int RUN_CYCLES    = TOTAL_RESULTS * 2 * 2;
    // Reset and load first, then the run twice over as margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + IMEM_WORDS + 2 * RUN_CYCLES + 50;

    // Opcode families of the reference model
    typedef enum int
    {
        FAM_UPPER,
        FAM_JAL,
        FAM_JALR,
        FAM_BRANCH,
        FAM_LOAD,
        FAM_STORE,
        FAM_ALU_IMM,
        FAM_ALU_REG,
        FAM_NONE
    } family_e;

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      run;
    logic                      imem_we;
    logic [AW-1:0]             imem_addr;
    rv_decode_pkg::word_t      imem_data;
    logic                      pipeline_ready;

    logic                      done;
    rv_decode_pkg::word_t      dec_pc;
    rv_decode_pkg::block_sel_t dec_block;
    rv_decode_pkg::reg_idx_t   dec_rd;
    rv_decode_pkg::reg_idx_t   dec_rs1;
    rv_decode_pkg::reg_idx_t   dec_rs2;
    logic                      dec_rs1_used;
    logic                      dec_rs2_used;
    rv_decode_pkg::funct3_t    dec_funct3;
    logic                      dec_iop;
    rv_decode_pkg::word_t      dec_imm;

    // Expected decode of the instruction at the head of the model
    rv_decode_pkg::word_t      exp_pc;
    rv_decode_pkg::block_sel_t exp_block;
    rv_decode_pkg::reg_idx_t   exp_rd;
    rv_decode_pkg::reg_idx_t   exp_rs1;
    rv_decode_pkg::reg_idx_t   exp_rs2;
    logic                      exp_rs1_used;
    logic                      exp_rs2_used;
    rv_decode_pkg::funct3_t    exp_funct3;
    logic                      exp_iop;
    rv_decode_pkg::word_t      exp_imm;

    // Memory image and the fetch-order list built from it
    rv_decode_pkg::word_t      mem_model [IMEM_WORDS];
    rv_decode_pkg::word_t      model_pc [$];
    rv_decode_pkg::word_t      model_instr [$];

    logic [31:0]               rng = 32'd16;
    int                        done_count = 0;

    rv_decode_top UUT
    (
        .i_clk            (clk),
        .i_reset          (reset),
        .i_run            (run),
        .i_imem_we        (imem_we),
        .i_imem_addr      (imem_addr),
        .i_imem_data      (imem_data),
        .i_pipeline_ready (pipeline_ready),
        .o_done           (done),
        .o_pc             (dec_pc),
        .o_block          (dec_block),
        .o_rd             (dec_rd),
        .o_rs1            (dec_rs1),
        .o_rs2            (dec_rs2),
        .o_rs1_used       (dec_rs1_used),
        .o_rs2_used       (dec_rs2_used),
        .o_funct3         (dec_funct3),
        .o_iop            (dec_iop),
        .o_imm            (dec_imm)
    );

    always
    begin
        #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Index 9 is FENCE, which the decoder leaves alone
    function automatic logic [6:0] opcode_for(input int idx);
        case (idx)
            0:       return `RV_OP_LUI;
            1:       return `RV_OP_AUIPC;
            2:       return `RV_OP_JAL;
            3:       return `RV_OP_JALR;
            4:       return `RV_OP_BRANCH;
            5:       return `RV_OP_LOAD;
            6:       return `RV_OP_STORE;
            7:       return `RV_OP_ALU_IMM;
            8:       return `RV_OP_ALU_REG;
            default: return 7'b0001111;
        endcase
    endfunction

    // Top field bit at position bits-1
    function automatic rv_decode_pkg::word_t sign_extend(input rv_decode_pkg::word_t v,
                                                         input int bits);
        rv_decode_pkg::word_t shifted;
        shifted = v << (32 - bits);
        return rv_decode_pkg::word_t'($signed(shifted) >>> (32 - bits));
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        stop_with_failure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
                                    name, got, expected));
    endtask

    //////////////////////////////////////////////////
    // Reference decode
    //////////////////////////////////////////////////

    task automatic reference_decode(input rv_decode_pkg::word_t instr);
        family_e fam;
        logic    uses_rd;
        case (instr[6:0])
            `RV_OP_LUI, `RV_OP_AUIPC: fam = FAM_UPPER;
            `RV_OP_JAL:               fam = FAM_JAL;
            `RV_OP_JALR:              fam = FAM_JALR;
            `RV_OP_BRANCH:            fam = FAM_BRANCH;
            `RV_OP_LOAD:              fam = FAM_LOAD;
            `RV_OP_STORE:             fam = FAM_STORE;
            `RV_OP_ALU_IMM:           fam = FAM_ALU_IMM;
            `RV_OP_ALU_REG:           fam = FAM_ALU_REG;
            default:                  fam = FAM_NONE;
        endcase
        // Register fields by instruction format
        uses_rd = fam inside {FAM_UPPER, FAM_JAL, FAM_JALR, FAM_LOAD, FAM_ALU_IMM, FAM_ALU_REG};
        exp_rs1_used = fam inside {FAM_JALR, FAM_BRANCH, FAM_LOAD, FAM_STORE,
                                   FAM_ALU_IMM, FAM_ALU_REG};
        exp_rs2_used = fam inside {FAM_BRANCH, FAM_STORE, FAM_ALU_REG};
        exp_rd  = uses_rd ? instr[11:7] : 5'd0;
        exp_rs1 = exp_rs1_used ? instr[19:15] : 5'd0;
        exp_rs2 = exp_rs2_used ? instr[24:20] : 5'd0;
        exp_funct3 = instr[14:12];
        exp_block  = '0;
        exp_iop    = 1'b0;
        exp_imm    = '0;
        case (fam)
            FAM_UPPER:
            begin
                exp_block[rv_decode_pkg::BLK_UPPER] = 1'b1;
                exp_iop = instr[5];
                exp_imm = {instr[31:12], 12'd0};
            end
            FAM_JAL, FAM_JALR:
            begin
                exp_block[rv_decode_pkg::BLK_UNCOND] = 1'b1;
                exp_iop = instr[3];
                if (fam == FAM_JAL)
                begin
                    exp_imm = sign_extend({11'd0, instr[31], instr[19:12], instr[20],
                                           instr[30:21], 1'b0}, 21);
                end
                else
                begin
                    exp_imm = sign_extend({20'd0, instr[31:20]}, 12);
                end
            end
            FAM_BRANCH:
            begin
                exp_block[rv_decode_pkg::BLK_COND] = 1'b1;
                exp_imm = sign_extend({19'd0, instr[31], instr[7], instr[30:25],
                                       instr[11:8], 1'b0}, 13);
            end
            FAM_LOAD, FAM_STORE:
            begin
                exp_block[rv_decode_pkg::BLK_MEM] = 1'b1;
                exp_iop = instr[5];
                if (fam == FAM_LOAD)
                begin
                    exp_imm = sign_extend({20'd0, instr[31:20]}, 12);
                end
                else
                begin
                    exp_imm = sign_extend({20'd0, instr[31:25], instr[11:7]}, 12);
                end
            end
            FAM_ALU_IMM:
            begin
                exp_block[rv_decode_pkg::BLK_ALU_IMM] = 1'b1;
                exp_iop = instr[30];
                exp_imm = sign_extend({20'd0, instr[31:20]}, 12);
            end
            FAM_ALU_REG:
            begin
                exp_block[rv_decode_pkg::BLK_ALU_REG] = 1'b1;
                exp_iop = instr[30];
            end
            default:
            begin
                exp_block = '0;
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // Result check on each done pulse
    //////////////////////////////////////////////////

    task automatic check_result();
        rv_decode_pkg::word_t instr;
        exp_pc = model_pc.pop_front();
        instr  = model_instr.pop_front();
        reference_decode(instr);
        assert (dec_pc == exp_pc) else value_mismatch("o_pc", dec_pc, exp_pc);
        assert ($onehot0(dec_block))
            else stop_with_failure("block select has more than one bit set");
        assert (dec_block == exp_block)
            else value_mismatch("o_block", 32'(dec_block), 32'(exp_block));
        assert (dec_rd == exp_rd) else value_mismatch("o_rd", 32'(dec_rd), 32'(exp_rd));
        assert (dec_rs1 == exp_rs1) else value_mismatch("o_rs1", 32'(dec_rs1), 32'(exp_rs1));
        assert (dec_rs2 == exp_rs2) else value_mismatch("o_rs2", 32'(dec_rs2), 32'(exp_rs2));
        assert (dec_rs1_used == exp_rs1_used)
            else value_mismatch("o_rs1_used", 32'(dec_rs1_used), 32'(exp_rs1_used));
        assert (dec_rs2_used == exp_rs2_used)
            else value_mismatch("o_rs2_used", 32'(dec_rs2_used), 32'(exp_rs2_used));
        assert (dec_funct3 == exp_funct3)
            else value_mismatch("o_funct3", 32'(dec_funct3), 32'(exp_funct3));
        assert (dec_iop == exp_iop) else value_mismatch("o_iop", 32'(dec_iop), 32'(exp_iop));
        assert (dec_imm == exp_imm) else value_mismatch("o_imm", dec_imm, exp_imm);
    endtask

    // Outputs settle after the rising edge
    // Only the modelled passes are compared
    always @(negedge clk)
    begin
        if (!reset && done && (done_count < TOTAL_RESULTS))
        begin
            check_result();
            done_count = done_count + 1;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Families in rotation from a random start, other bits random
    task automatic load_program();
        int                   rot;
        rv_decode_pkg::word_t word;
        rng = xorshift32(rng);
        rot = int'(rng % 32'd10);
        for (int i = 0; i < IMEM_WORDS; i++)
        begin
            rng  = xorshift32(rng);
            word = {rng[31:7], opcode_for((i + rot) % 10)};
            mem_model[i] = word;
            imem_we   = 1'b1;
            imem_addr = AW'(i);
            imem_data = word;
            @(negedge clk);
        end
        imem_we = 1'b0;
    endtask

    // Sequential fetch order, wrapping through memory
    task automatic build_model();
        for (int p = 0; p < PASSES; p++)
        begin
            for (int i = 0; i < IMEM_WORDS; i++)
            begin
                model_pc.push_back(rv_decode_pkg::word_t'(i) << 2);
                model_instr.push_back(mem_model[i]);
            end
        end
    endtask

    initial
    begin
        reset          = 1'b1;
        run            = 1'b0;
        imem_we        = 1'b0;
        imem_addr      = '0;
        imem_data      = '0;
        pipeline_ready = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        load_program();
        build_model();
        @(negedge clk);
        run            = 1'b1;
        pipeline_ready = 1'b1;
        // Random back-pressure, never low two cycles running
        while (done_count < TOTAL_RESULTS)
        begin
            @(negedge clk);
            rng = xorshift32(rng);
            pipeline_ready = pipeline_ready ? rng[0] : 1'b1;
        end
        @(negedge clk);
        $display("All checks passed");
        $finish;
    end

    // Watchdog
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure("watchdog expired, the decoder stopped producing results");
    end

endmodule

`default_nettype wire

//--- rv_decode_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module rv_decode_chk
(
    input wire logic i_clk,
    input wire logic i_reset,
    input wire logic i_pipeline_ready,
    input wire logic i_push,
    input wire logic i_pop,
    input wire logic i_full,
    input wire logic i_empty,
    input wire logic i_done
);

    localparam int DEPTH = `RV_QUEUE_DEPTH;
    localparam int CW    = $clog2(DEPTH + 1);

    // Shadow occupancy of the queue
    logic [CW-1:0] occ;
    // Set by the first push after reset
    logic          seen_push;

    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            occ       <= '0;
            seen_push <= 1'b0;
        end
        else
        begin
            occ <= occ + CW'(i_push) - CW'(i_pop);
            if (i_push)
            begin
                seen_push <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Decoder handshake
    //////////////////////////////////////////////////

    // Pop to done in exactly two cycles
    a_pop_to_done: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pop |-> ##2 i_done) else $error("pop not followed by done two cycles later");

    a_done_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_done |=> !i_done) else $error("done high on two consecutive cycles");

    // Back-pressure holds the decoder
    a_no_pop_stalled: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_pipeline_ready |-> !i_pop) else $error("pop while pipeline not ready");

    //////////////////////////////////////////////////
    // Queue levels
    //////////////////////////////////////////////////

    a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset)
        i_full |-> !i_push) else $error("push into a full queue");

    a_levels: assert property (@(posedge i_clk) disable iff (i_reset)
        (occ <= CW'(DEPTH)) && (i_full == (occ == CW'(DEPTH))) && (i_empty == (occ == '0)))
        else $error("queue full or empty level disagrees with occupancy");

    // Quiet start until the first push
    a_quiet_start: assert property (@(posedge i_clk) disable iff (i_reset)
        !seen_push |-> (i_empty && !i_done)) else $error("activity before the first push");

endmodule

bind rv_decode_top rv_decode_chk u_chk
(
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_pipeline_ready (i_pipeline_ready),
    .i_push           (push),
    .i_pop            (pop),
    .i_full           (q_full),
    .i_empty          (q_empty),
    .i_done           (o_done)
);

`default_nettype wire

//--- rv_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module rv_decode_top
(
    input  wire logic                                 i_clk,
    input  wire logic                                 i_reset,
    input  wire logic                                 i_run,
    input  wire logic                                 i_imem_we,
    input  wire logic [$clog2(`RV_IMEM_WORDS)-1:0]    i_imem_addr,
    input  wire rv_decode_pkg::word_t                 i_imem_data,
    input  wire logic                                 i_pipeline_ready,
    output logic                                      o_done,
    output rv_decode_pkg::word_t                      o_pc,
    output rv_decode_pkg::block_sel_t                 o_block,
    output rv_decode_pkg::reg_idx_t                   o_rd,
    output rv_decode_pkg::reg_idx_t                   o_rs1,
    output rv_decode_pkg::reg_idx_t                   o_rs2,
    output logic                                      o_rs1_used,
    output logic                                      o_rs2_used,
    output rv_decode_pkg::funct3_t                    o_funct3,
    output logic                                      o_iop,
    output rv_decode_pkg::word_t                      o_imm
);

    // Fetch to queue
    logic                 push;
    rv_decode_pkg::word_t push_pc;
    rv_decode_pkg::word_t push_instr;
    logic                 q_full;

    // Queue to decoder
    logic                 q_empty;
    rv_decode_pkg::word_t head_pc;
    rv_decode_pkg::word_t head_instr;
    logic                 pop;

    //////////////////////////////////////////////////
    // Producer, buffer and consumer
    //////////////////////////////////////////////////

    instr_fetch
    #(
        .IMEM_WORDS (`RV_IMEM_WORDS)
    )
    u_fetch
    (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_run        (i_run),
        .i_imem_we    (i_imem_we),
        .i_imem_addr  (i_imem_addr),
        .i_imem_data  (i_imem_data),
        .i_full       (q_full),
        .o_push       (push),
        .o_push_pc    (push_pc),
        .o_push_instr (push_instr)
    );

    instr_queue
    #(
        .DEPTH (`RV_QUEUE_DEPTH)
    )
    u_queue
    (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_push       (push),
        .i_push_pc    (push_pc),
        .i_push_instr (push_instr),
        .i_pop        (pop),
        .o_full       (q_full),
        .o_empty      (q_empty),
        .o_head_pc    (head_pc),
        .o_head_instr (head_instr)
    );

    instruction_decoder u_decoder
    (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_pipeline_ready (i_pipeline_ready),
        .i_empty          (q_empty),
        .i_instr          (head_instr),
        .i_pc             (head_pc),
        .o_pop            (pop),
        .o_done           (o_done),
        .o_pc             (o_pc),
        .o_block          (o_block),
        .o_rd             (o_rd),
        .o_rs1            (o_rs1),
        .o_rs2            (o_rs2),
        .o_rs1_used       (o_rs1_used),
        .o_rs2_used       (o_rs2_used),
        .o_funct3         (o_funct3),
        .o_iop            (o_iop),
        .o_imm            (o_imm)
    );

endmodule

`default_nettype wire

//--- instruction_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module instruction_decoder
(
    input  wire logic                  i_clk,
    input  wire logic                  i_reset,
    input  wire logic                  i_pipeline_ready,
    input  wire logic                  i_empty,
    input  wire rv_decode_pkg::word_t  i_instr,
    input  wire rv_decode_pkg::word_t  i_pc,
    output logic                       o_pop,
    output logic                       o_done,
    output rv_decode_pkg::word_t       o_pc,
    output rv_decode_pkg::block_sel_t  o_block,
    output rv_decode_pkg::reg_idx_t    o_rd,
    output rv_decode_pkg::reg_idx_t    o_rs1,
    output rv_decode_pkg::reg_idx_t    o_rs2,
    output logic                       o_rs1_used,
    output logic                       o_rs2_used,
    output rv_decode_pkg::funct3_t     o_funct3,
    output logic                       o_iop,
    output rv_decode_pkg::word_t       o_imm
);

    rv_decode_pkg::decode_state_e state;
    rv_decode_pkg::decode_state_e state_next;

    // Entry taken from the queue
    rv_decode_pkg::word_t cap_instr;
    rv_decode_pkg::word_t cap_pc;

    // Combinational decode results
    rv_decode_pkg::block_sel_t d_block;
    rv_decode_pkg::reg_idx_t   d_rd;
    rv_decode_pkg::reg_idx_t   d_rs1;
    rv_decode_pkg::reg_idx_t   d_rs2;
    logic                      d_rs1_used;
    logic                      d_rs2_used;
    logic                      d_iop;
    rv_decode_pkg::word_t      d_imm;

    //////////////////////////////////////////////////
    // Decode of one instruction word
    //////////////////////////////////////////////////

    function automatic void decode
    (
        input  rv_decode_pkg::word_t       instr,
        output rv_decode_pkg::block_sel_t  blk,
        output rv_decode_pkg::reg_idx_t    rd,
        output rv_decode_pkg::reg_idx_t    rs1,
        output rv_decode_pkg::reg_idx_t    rs2,
        output logic                       rs1_used,
        output logic                       rs2_used,
        output logic                       iop,
        output rv_decode_pkg::word_t       imm
    );
        // Immediate of every format
        rv_decode_pkg::word_t imm_i;
        rv_decode_pkg::word_t imm_s;
        rv_decode_pkg::word_t imm_b;
        rv_decode_pkg::word_t imm_u;
        rv_decode_pkg::word_t imm_j;

        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'b0};
        imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

        // Unknown opcode leaves everything cleared
        blk      = '0;
        rd       = '0;
        rs1      = '0;
        rs2      = '0;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        iop      = 1'b0;
        imm      = '0;

        case (instr[6:0])
            `RV_OP_LUI, `RV_OP_AUIPC:
            begin
                blk[rv_decode_pkg::BLK_UPPER] = 1'b1;
                iop = instr[5];
                rd  = instr[11:7];
                imm = imm_u;
            end
            `RV_OP_JAL:
            begin
                blk[rv_decode_pkg::BLK_UNCOND] = 1'b1;
                // Bit 3 tells JAL from JALR
                iop = instr[3];
                rd  = instr[11:7];
                imm = imm_j;
            end
            `RV_OP_JALR:
            begin
                blk[rv_decode_pkg::BLK_UNCOND] = 1'b1;
                iop      = instr[3];
                rd       = instr[11:7];
                rs1      = instr[19:15];
                rs1_used = 1'b1;
                imm      = imm_i;
            end
            `RV_OP_BRANCH:
            begin
                blk[rv_decode_pkg::BLK_COND] = 1'b1;
                // No invert for branches
                rs1      = instr[19:15];
                rs2      = instr[24:20];
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                imm      = imm_b;
            end
            `RV_OP_LOAD:
            begin
                blk[rv_decode_pkg::BLK_MEM] = 1'b1;
                // Low for load, high for store
                iop      = instr[5];
                rd       = instr[11:7];
                rs1      = instr[19:15];
                rs1_used = 1'b1;
                imm      = imm_i;
            end
            `RV_OP_STORE:
            begin
                blk[rv_decode_pkg::BLK_MEM] = 1'b1;
                iop      = instr[5];
                rs1      = instr[19:15];
                rs2      = instr[24:20];
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                imm      = imm_s;
            end
            `RV_OP_ALU_IMM:
            begin
                blk[rv_decode_pkg::BLK_ALU_IMM] = 1'b1;
                // SRAI marker
                iop      = instr[30];
                rd       = instr[11:7];
                rs1      = instr[19:15];
                rs1_used = 1'b1;
                imm      = imm_i;
            end
            `RV_OP_ALU_REG:
            begin
                blk[rv_decode_pkg::BLK_ALU_REG] = 1'b1;
                // SUB and SRA marker
                iop      = instr[30];
                rd       = instr[11:7];
                rs1      = instr[19:15];
                rs2      = instr[24:20];
                rs1_used = 1'b1;
                rs2_used = 1'b1;
            end
            default:
            begin
                blk = '0;
            end
        endcase
    endfunction

    always_comb
    begin
        decode(cap_instr, d_block, d_rd, d_rs1, d_rs2, d_rs1_used, d_rs2_used, d_iop, d_imm);
    end

    //////////////////////////////////////////////////
    // Wait and decode FSM
    //////////////////////////////////////////////////

    // Take the head when downstream is ready and queue has one
    assign o_pop = (state == rv_decode_pkg::DE_WAIT) && i_pipeline_ready && !i_empty;

    always_comb
    begin
        state_next = state;
        case (state)
            rv_decode_pkg::DE_WAIT:
            begin
                if (o_pop)
                begin
                    state_next = rv_decode_pkg::DE_DECODE;
                end
            end
            rv_decode_pkg::DE_DECODE:
            begin
                // Single decode cycle
                state_next = rv_decode_pkg::DE_WAIT;
            end
        endcase
    end

    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            state  <= rv_decode_pkg::DE_WAIT;
            o_done <= 1'b0;
        end
        else
        begin
            state  <= state_next;
            // Pulse follows the decode cycle
            o_done <= (state == rv_decode_pkg::DE_DECODE);
        end
    end

    // Capture head entry on the pop
    always_ff @(posedge i_clk)
    begin
        if (o_pop)
        begin
            cap_instr <= i_instr;
            cap_pc    <= i_pc;
        end
    end

    // Outputs hold until the next decode
    always_ff @(posedge i_clk)
    begin
        if (state == rv_decode_pkg::DE_DECODE)
        begin
            o_pc       <= cap_pc;
            o_block    <= d_block;
            o_rd       <= d_rd;
            o_rs1      <= d_rs1;
            o_rs2      <= d_rs2;
            o_rs1_used <= d_rs1_used;
            o_rs2_used <= d_rs2_used;
            o_funct3   <= cap_instr[14:12];
            o_iop      <= d_iop;
            o_imm      <= d_imm;
        end
    end

endmodule

`default_nettype wire

//--- instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module instr_queue
#(
    parameter int DEPTH = 4
)
(
    input  wire logic                  i_clk,
    input  wire logic                  i_reset,
    input  wire logic                  i_push,
    input  wire rv_decode_pkg::word_t  i_push_pc,
    input  wire rv_decode_pkg::word_t  i_push_instr,
    input  wire logic                  i_pop,
    output logic                       o_full,
    output logic                       o_empty,
    output rv_decode_pkg::word_t       o_head_pc,
    output rv_decode_pkg::word_t       o_head_instr
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    // Entry storage, pc and instruction side by side
    rv_decode_pkg::word_t pc_mem    [DEPTH];
    rv_decode_pkg::word_t instr_mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    // Qualified strobes
    logic do_push;
    logic do_pop;

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    // Levels straight from occupancy
    assign o_full  = (count == CW'(DEPTH));
    assign o_empty = (count == '0);

    // Oldest entry shown at the head
    assign o_head_pc    = pc_mem[rd_ptr];
    assign o_head_instr = instr_mem[rd_ptr];

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave count alone
            if (do_push && !do_pop)
            begin
                count <= count + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage write
    always_ff @(posedge i_clk)
    begin
        if (do_push)
        begin
            pc_mem[wr_ptr]    <= i_push_pc;
            instr_mem[wr_ptr] <= i_push_instr;
        end
    end

endmodule

`default_nettype wire

//--- instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch
#(
    parameter int IMEM_WORDS = 16
)
(
    input  wire logic                            i_clk,
    input  wire logic                            i_reset,
    input  wire logic                            i_run,
    input  wire logic                            i_imem_we,
    input  wire logic [$clog2(IMEM_WORDS)-1:0]   i_imem_addr,
    input  wire rv_decode_pkg::word_t            i_imem_data,
    input  wire logic                            i_full,
    output logic                                 o_push,
    output rv_decode_pkg::word_t                 o_push_pc,
    output rv_decode_pkg::word_t                 o_push_instr
);

    localparam int AW = $clog2(IMEM_WORDS);

    // Instruction storage
    rv_decode_pkg::word_t mem [IMEM_WORDS];

    // Address of the word sitting in the prefetch register
    logic [AW-1:0] fetch_ptr;
    logic [AW-1:0] fetch_ptr_inc;
    logic [AW-1:0] read_addr;

    // Prefetched word and its valid flag
    rv_decode_pkg::word_t pf_word;
    logic                 pf_valid;

    //////////////////////////////////////////////////
    // Push control
    //////////////////////////////////////////////////

    // Only push a valid word while running and queue has room
    assign o_push       = i_run && !i_full && pf_valid;
    assign o_push_instr = pf_word;
    // Byte address of the word
    assign o_push_pc    = rv_decode_pkg::word_t'(fetch_ptr) << 2;

    // Wrap after the last word
    assign fetch_ptr_inc = (fetch_ptr == AW'(IMEM_WORDS - 1)) ? '0 : fetch_ptr + 1'b1;

    // Read ahead to the next word when this one goes out
    assign read_addr = o_push ? fetch_ptr_inc : fetch_ptr;

    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            fetch_ptr <= '0;
            pf_valid  <= 1'b0;
        end
        else
        begin
            // First read lands one cycle out of reset
            pf_valid <= 1'b1;
            if (o_push)
            begin
                fetch_ptr <= fetch_ptr_inc;
            end
        end
    end

    //////////////////////////////////////////////////
    // Memory write port and synchronous read
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_imem_we)
        begin
            mem[i_imem_addr] <= i_imem_data;
        end
        // Write to the address being read wins
        if (i_imem_we && (i_imem_addr == read_addr))
        begin
            pf_word <= i_imem_data;
        end
        else
        begin
            pf_word <= mem[read_addr];
        end
    end

endmodule

`default_nettype wire

//--- rv_decode_pkg.sv
`default_nettype none

package rv_decode_pkg;

    //////////////////////////////////////////////////
    // Widths with a meaning
    //////////////////////////////////////////////////

    // Instruction, program counter or immediate
    typedef logic [31:0] word_t;

    // Register index x0 to x31
    typedef logic [4:0] reg_idx_t;

    // Operation within an execution block
    typedef logic [2:0] funct3_t;

    // One-hot execution block select
    typedef logic [5:0] block_sel_t;

    //////////////////////////////////////////////////
    // Block select bit positions
    //////////////////////////////////////////////////

    typedef enum logic [2:0]
    {
        BLK_UPPER   = 3'd0,  // LUI and AUIPC
        BLK_UNCOND  = 3'd1,  // JAL and JALR
        BLK_COND    = 3'd2,  // BEQ through BGEU
        BLK_MEM     = 3'd3,  // Loads and stores
        BLK_ALU_IMM = 3'd4,  // ALU with immediate operand
        BLK_ALU_REG = 3'd5   // ALU with register operand
    } block_bit_e;

    // Decoder FSM
    typedef enum logic
    {
        DE_WAIT   = 1'b0,
        DE_DECODE = 1'b1
    } decode_state_e;

endpackage

`default_nettype wire

//--- rv_decode_params.svh
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

//////////////////////////////////////////////////
// Opcode values of the decoded families
//////////////////////////////////////////////////

// Upper immediate
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
// Jumps
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
// Conditional branches
`define RV_OP_BRANCH    7'b1100011
// Memory access
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
// Arithmetic and logic
`define RV_OP_ALU_IMM   7'b0010011
`define RV_OP_ALU_REG   7'b0110011

//////////////////////////////////////////////////
// Sizes
//////////////////////////////////////////////////

// Entries in the fetch to decode queue
`define RV_QUEUE_DEPTH  4
// Words in the instruction memory
`define RV_IMEM_WORDS   16

`endif
